// ==== design/soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Address map, inclusive bounds
`define ROM_BASE    32'h0000_0000
`define ROM_LAST    32'h0000_3FFF

`define SENSOR_BASE 32'h1000_0000
`define SENSOR_LAST 32'h1000_03FF

`define DRAM_BASE   32'h2000_0000
`define DRAM_LAST   32'h201F_FFFF

// Sensor buffer
`define SENSOR_DEPTH    64     // Words
`define SENSOR_CTRL_OFS 10'h200 // Bit 0 enable, bit 1 interrupt
`define SENSOR_CLR_OFS  10'h204

// DRAM wait cycles
`define DRAM_TRCD 2 // ACT to READ/WRITE
`define DRAM_TRP  2 // PRE to next ACT

`endif

// ==== design/soc_pkg.sv ====
package soc_pkg;

  typedef logic [31:0] addr_t;   // Byte address
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strobe_t; // Byte enables, also DRAM write masks

  typedef logic [11:0] rom_addr_t; // ROM word address
  typedef logic [10:0] row_t;      // Same width as the DRAM address pins
  typedef logic [7:0]  col_t;

  // Target picked by the request decoder
  typedef enum logic [1:0] {
    ROM,
    DRAM,
    SENSOR,
    NONE
  } region_t;

  // DRAM command sequence
  typedef enum logic [2:0] {
    IDLE,
    ACT,
    RCD,    // Activate to command wait
    CMD,    // READ or WRITE
    WAIT_Q, // Read data pending
    PRE,
    RP      // Precharge wait
  } dram_state_t;

endpackage

// ==== design/req_decoder.sv ====
`include "soc_config.svh"

module req_decoder (
  input  logic             clk,
  input  logic             rst_sync,
  input  logic             req,
  input  logic             we,
  input  soc_pkg::addr_t   addr,
  input  soc_pkg::word_t   wdata,
  input  soc_pkg::strobe_t wstrb,
  input  logic             done,
  output logic             start_rom,
  output logic             start_dram,
  output logic             start_sensor,
  output logic             start_none,
  output logic             we_q,
  output soc_pkg::addr_t   addr_q,
  output soc_pkg::word_t   wdata_q,
  output soc_pkg::strobe_t wstrb_q
);
  import soc_pkg::*;

  logic    busy;
  logic    accept; // New request taken this cycle
  region_t region;

  assign accept = req & ~busy;

  always_comb begin
    if (addr >= `ROM_BASE && addr <= `ROM_LAST) region = ROM;
    else if (addr >= `SENSOR_BASE && addr <= `SENSOR_LAST) region = SENSOR;
    else if (addr >= `DRAM_BASE && addr <= `DRAM_LAST) region = DRAM;
    else region = NONE; // Answered by the default slave
  end

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      busy         <= 1'b0;
      start_rom    <= 1'b0;
      start_dram   <= 1'b0;
      start_sensor <= 1'b0;
      start_none   <= 1'b0;
    end else begin
      start_rom    <= accept && (region == ROM);
      start_dram   <= accept && (region == DRAM);
      start_sensor <= accept && (region == SENSOR);
      start_none   <= accept && (region == NONE);
      if (accept) busy <= 1'b1;
      else if (done) busy <= 1'b0; // Host may issue the next request
    end
  end

  // Request fields held until done
  always_ff @(posedge clk) begin
    if (accept) begin
      we_q    <= we;
      addr_q  <= addr;
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
  end

endmodule

// ==== design/rom_port.sv ====
module rom_port (
  input  logic               clk,
  input  logic               rst_sync,
  input  logic               start,
  input  logic               we,
  input  soc_pkg::addr_t     addr,
  input  soc_pkg::word_t     ROM_out,
  output logic               ROM_read,
  output logic               ROM_enable,
  output soc_pkg::rom_addr_t ROM_address,
  output logic               rom_done,
  output soc_pkg::word_t     rom_data,
  output logic               rom_err
);

  logic rd_start;
  logic wr_start; // ROM is read only

  assign rd_start = start & ~we;
  assign wr_start = start & we;

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      ROM_enable <= 1'b0;
      ROM_read   <= 1'b0;
      rom_done   <= 1'b0;
      rom_err    <= 1'b0;
    end else begin
      // One cycle access strobe
      ROM_enable <= rd_start;
      ROM_read   <= rd_start;
      // Write is refused right away, a read finishes once ROM_out is valid
      rom_done   <= wr_start | ROM_enable;
      rom_err    <= wr_start;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_start) ROM_address <= addr[13:2];
  end

  // Word from the ROM, zero on a refused write
  always_comb begin
    if (rom_done && !rom_err) rom_data = ROM_out;
    else rom_data = '0;
  end

endmodule

// ==== design/dram_ctrl.sv ====
`include "soc_config.svh"

module dram_ctrl (
  input  logic             clk,
  input  logic             rst_sync,
  input  logic             start,
  input  logic             we,
  input  soc_pkg::addr_t   addr,
  input  soc_pkg::word_t   wdata,
  input  soc_pkg::strobe_t wstrb,
  input  logic             DRAM_valid,
  input  soc_pkg::word_t   DRAM_Q,
  output logic             DRAM_CSn,
  output soc_pkg::strobe_t DRAM_WEn,
  output logic             DRAM_RASn,
  output logic             DRAM_CASn,
  output soc_pkg::row_t    DRAM_A,
  output soc_pkg::word_t   DRAM_D,
  output logic             dram_done,
  output soc_pkg::word_t   dram_data
);
  import soc_pkg::*;

  localparam logic [3:0] RCD_LAST = 4'(`DRAM_TRCD - 1);
  localparam logic [3:0] RP_LAST  = 4'(`DRAM_TRP - 1);

  dram_state_t state;
  dram_state_t state_next;
  logic [3:0]  wait_cnt;
  row_t        row;
  col_t        col;

  // Pin values decoded from the state, registered below
  logic    csn_next;
  logic    rasn_next;
  logic    casn_next;
  strobe_t wen_next;
  row_t    a_next;
  word_t   d_next;

  assign row = addr[20:10];
  assign col = addr[9:2];

  always_comb begin
    state_next = state;
    case (state)
      IDLE:    if (start) state_next = ACT;
      ACT:     state_next = RCD;
      RCD:     if (wait_cnt == RCD_LAST) state_next = CMD;
      CMD:     state_next = we ? PRE : WAIT_Q;
      WAIT_Q:  if (DRAM_valid) state_next = PRE; // Read latency unknown
      PRE:     state_next = RP;
      RP:      if (wait_cnt == RP_LAST) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_comb begin
    csn_next  = (state == IDLE); // Selected for the whole sequence
    rasn_next = 1'b1;
    casn_next = 1'b1;
    wen_next  = '1;
    a_next    = '0;
    d_next    = '0;
    case (state)
      ACT: begin
        rasn_next = 1'b0;
        a_next    = row;
      end
      CMD: begin
        casn_next = 1'b0;
        a_next    = row_t'(col);
        if (we) begin
          wen_next = ~wstrb; // Active low byte writes
          d_next   = wdata;
        end
      end
      PRE: begin
        rasn_next = 1'b0;
        wen_next  = '0;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      state     <= IDLE;
      wait_cnt  <= '0;
      dram_done <= 1'b0;
      DRAM_CSn  <= 1'b1;
      DRAM_WEn  <= '1;
      DRAM_RASn <= 1'b1;
      DRAM_CASn <= 1'b1;
      DRAM_A    <= '0;
      DRAM_D    <= '0;
    end else begin
      state <= state_next;
      if ((state == RCD || state == RP) && state_next == state) wait_cnt <= wait_cnt + 4'd1;
      else wait_cnt <= '0;
      dram_done <= (state == RP) && (state_next == IDLE);
      DRAM_CSn  <= csn_next;
      DRAM_WEn  <= wen_next;
      DRAM_RASn <= rasn_next;
      DRAM_CASn <= casn_next;
      DRAM_A    <= a_next;
      DRAM_D    <= d_next;
    end
  end

  // Writes return a zero word
  always_ff @(posedge clk) begin
    if (start) dram_data <= '0;
    else if (state == WAIT_Q && DRAM_valid) dram_data <= DRAM_Q;
  end

endmodule

// ==== design/sensor_buffer.sv ====
`include "soc_config.svh"

module sensor_buffer (
  input  logic           clk,
  input  logic           rst_sync,
  input  logic           start,
  input  logic           we,
  input  soc_pkg::addr_t addr,
  input  soc_pkg::word_t wdata,
  input  logic           sensor_ready,
  input  soc_pkg::word_t sensor_out,
  output logic           sensor_en,
  output logic           sensor_interrupt,
  output logic           sensor_done,
  output soc_pkg::word_t sensor_data
);
  import soc_pkg::*;

  localparam int             IDX_W     = $clog2(`SENSOR_DEPTH);
  localparam logic [IDX_W:0] DEPTH_CNT = `SENSOR_DEPTH;
  localparam logic [9:0]     BUF_BYTES = `SENSOR_DEPTH * 4;

  word_t          buf_mem [`SENSOR_DEPTH];
  logic [IDX_W:0] fill_cnt; // Words stored so far
  logic           enable;
  logic           full;
  logic           store;
  logic [9:0]     ofs;
  logic           ctrl_hit;
  logic           clr_hit;
  word_t          rd_word;

  assign ofs      = addr[9:0];
  assign ctrl_hit = (ofs == `SENSOR_CTRL_OFS);
  assign clr_hit  = (ofs == `SENSOR_CLR_OFS);
  assign full     = (fill_cnt == DEPTH_CNT);

  assign sensor_en = enable & ~full;
  assign store     = sensor_en & sensor_ready;

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      enable           <= 1'b0;
      fill_cnt         <= '0;
      sensor_interrupt <= 1'b0;
      sensor_done      <= 1'b0;
    end else begin
      sensor_done <= start;
      if (start && we && ctrl_hit) enable <= wdata[0];
      if (start && we && clr_hit) begin
        fill_cnt         <= '0;
        sensor_interrupt <= 1'b0;
      end else if (store) begin
        fill_cnt <= fill_cnt + 1'b1;
        if (fill_cnt == DEPTH_CNT - 1'b1) sensor_interrupt <= 1'b1; // Last word in
      end
    end
  end

  always_ff @(posedge clk) begin
    if (store) buf_mem[fill_cnt[IDX_W-1:0]] <= sensor_out;
  end

  always_comb begin
    if (ctrl_hit) rd_word = {30'b0, sensor_interrupt, enable};
    else if (ofs < BUF_BYTES) rd_word = buf_mem[addr[IDX_W+1:2]];
    else rd_word = '0;
  end

  always_ff @(posedge clk) begin
    if (start) sensor_data <= we ? '0 : rd_word;
  end

endmodule

// ==== design/resp_mux.sv ====
module resp_mux (
  input  logic           clk,
  input  logic           rst_sync,
  input  logic           rom_done,
  input  soc_pkg::word_t rom_data,
  input  logic           rom_err,
  input  logic           dram_done,
  input  soc_pkg::word_t dram_data,
  input  logic           sensor_done,
  input  soc_pkg::word_t sensor_data,
  input  logic           start_none,
  output logic           done,
  output soc_pkg::word_t rdata,
  output logic           err
);

  logic none_q; // Default slave answers one cycle after its start

  always_ff @(posedge clk or posedge rst_sync) begin
    if (rst_sync) begin
      none_q <= 1'b0;
      done   <= 1'b0;
      err    <= 1'b0;
    end else begin
      none_q <= start_none;
      done   <= rom_done | dram_done | sensor_done | none_q;
      err    <= (rom_done & rom_err) | none_q;
    end
  end

  // Only one target finishes per request
  always_ff @(posedge clk) begin
    if (rom_done) rdata <= rom_data; // Already zero for a refused write
    else if (dram_done) rdata <= dram_data;
    else if (sensor_done) rdata <= sensor_data;
    else if (none_q) rdata <= '0;
  end

endmodule

// ==== design/soc_top.sv ====
module soc_top (
  input  logic               clk,
  input  logic               rst_sync,
  // Host
  input  logic               req,
  input  logic               we,
  input  soc_pkg::addr_t     addr,
  input  soc_pkg::word_t     wdata,
  input  soc_pkg::strobe_t   wstrb,
  output logic               done,
  output soc_pkg::word_t     rdata,
  output logic               err,
  // ROM
  input  soc_pkg::word_t     ROM_out,
  output logic               ROM_read,
  output logic               ROM_enable,
  output soc_pkg::rom_addr_t ROM_address,
  // DRAM
  input  logic               DRAM_valid,
  input  soc_pkg::word_t     DRAM_Q,
  output logic               DRAM_CSn,
  output soc_pkg::strobe_t   DRAM_WEn,
  output logic               DRAM_RASn,
  output logic               DRAM_CASn,
  output soc_pkg::row_t      DRAM_A,
  output soc_pkg::word_t     DRAM_D,
  // Sensor
  input  logic               sensor_ready,
  input  soc_pkg::word_t     sensor_out,
  output logic               sensor_en,
  output logic               sensor_interrupt
);
  import soc_pkg::*;

  logic    start_rom, start_dram, start_sensor, start_none;
  logic    we_q;
  addr_t   addr_q;
  word_t   wdata_q;
  strobe_t wstrb_q;

  logic  rom_done, rom_err;
  word_t rom_data;
  logic  dram_done;
  word_t dram_data;
  logic  sensor_done;
  word_t sensor_data;

  req_decoder req_decoder0 (
    .clk (clk), .rst_sync (rst_sync), .req (req), .we (we), .addr (addr),
    .wdata (wdata), .wstrb (wstrb), .done (done),
    .start_rom (start_rom), .start_dram (start_dram),
    .start_sensor (start_sensor), .start_none (start_none),
    .we_q (we_q), .addr_q (addr_q), .wdata_q (wdata_q), .wstrb_q (wstrb_q)
  );

  rom_port rom_port0 (
    .clk (clk), .rst_sync (rst_sync), .start (start_rom), .we (we_q), .addr (addr_q),
    .ROM_out (ROM_out), .ROM_read (ROM_read), .ROM_enable (ROM_enable),
    .ROM_address (ROM_address),
    .rom_done (rom_done), .rom_data (rom_data), .rom_err (rom_err)
  );

  dram_ctrl dram_ctrl0 (
    .clk (clk), .rst_sync (rst_sync), .start (start_dram), .we (we_q), .addr (addr_q),
    .wdata (wdata_q), .wstrb (wstrb_q), .DRAM_valid (DRAM_valid), .DRAM_Q (DRAM_Q),
    .DRAM_CSn (DRAM_CSn), .DRAM_WEn (DRAM_WEn), .DRAM_RASn (DRAM_RASn),
    .DRAM_CASn (DRAM_CASn), .DRAM_A (DRAM_A), .DRAM_D (DRAM_D),
    .dram_done (dram_done), .dram_data (dram_data)
  );

  sensor_buffer sensor_buffer0 (
    .clk (clk), .rst_sync (rst_sync), .start (start_sensor), .we (we_q), .addr (addr_q),
    .wdata (wdata_q), .sensor_ready (sensor_ready), .sensor_out (sensor_out),
    .sensor_en (sensor_en), .sensor_interrupt (sensor_interrupt),
    .sensor_done (sensor_done), .sensor_data (sensor_data)
  );

  // Done also releases the decoder
  resp_mux resp_mux0 (
    .clk (clk), .rst_sync (rst_sync),
    .rom_done (rom_done), .rom_data (rom_data), .rom_err (rom_err),
    .dram_done (dram_done), .dram_data (dram_data),
    .sensor_done (sensor_done), .sensor_data (sensor_data),
    .start_none (start_none), .done (done), .rdata (rdata), .err (err)
  );

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock #(
  parameter int PERIOD_NS = 8
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk; // Free running, 50 percent duty
  end

endmodule

// ==== testbench/soc_tb.sv ====
`include "soc_config.svh"

module soc_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import soc_pkg::*;

  logic clk;
  logic rst_sync;
  logic req;
  logic we;
  addr_t addr;
  word_t wdata;
  strobe_t wstrb;
  logic done;
  word_t rdata;
  logic err;
  word_t rom_out;
  logic rom_read;
  logic rom_enable;
  rom_addr_t rom_address;
  logic dram_valid;
  word_t dram_q;
  logic dram_csn;
  strobe_t dram_wen;
  logic dram_rasn;
  logic dram_casn;
  row_t dram_a;
  word_t dram_d;
  logic sensor_ready;
  word_t sensor_out;
  logic sensor_en;
  logic sensor_interrupt;

  // Pattern table
  string   pat_op[$];
  addr_t   pat_addr[$];
  word_t   pat_data[$];
  strobe_t pat_strb[$];
  word_t   pat_rdata[$];
  logic    pat_err[$];

  int cycle_count = 0;
  int cycle_limit = 0; // Set once the patterns are known
  int done_count = 0;
  int req_count = 0;
  int sensor_words = 0;  // Words handed to the DUT by the sensor model
  word_t dram_mem [logic [18:0]];

  tb_clock #(.PERIOD_NS(8)) clock0 (.clk(clk));

  soc_top dut0 (
    .clk (clk), .rst_sync (rst_sync),
    .req (req), .we (we), .addr (addr), .wdata (wdata), .wstrb (wstrb),
    .done (done), .rdata (rdata), .err (err),
    .ROM_out (rom_out), .ROM_read (rom_read), .ROM_enable (rom_enable),
    .ROM_address (rom_address),
    .DRAM_valid (dram_valid), .DRAM_Q (dram_q), .DRAM_CSn (dram_csn), .DRAM_WEn (dram_wen),
    .DRAM_RASn (dram_rasn), .DRAM_CASn (dram_casn), .DRAM_A (dram_a), .DRAM_D (dram_d),
    .sensor_ready (sensor_ready), .sensor_out (sensor_out), .sensor_en (sensor_en),
    .sensor_interrupt (sensor_interrupt)
  );

  function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic in_dram(input addr_t a);
    return (a >= `DRAM_BASE) && (a <= `DRAM_LAST);
  endfunction

  // Zero means the latency is not fixed
  function automatic int fixed_latency(input logic wr, input addr_t a);
    if (in_dram(a)) return 0;
    if (a <= `ROM_LAST && !wr) return 4;
    return 3;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] value,
                             input logic [31:0] expected);
    if (value !== expected) begin
      fail_run($sformatf("Error at %0t ns: %s is 0x%h, expected 0x%h",
                         $time, name, value, expected));
    end
  endtask

  task automatic check_dram_idle();
    check_value("DRAM_CSn", dram_csn, 1);
    check_value("DRAM_RASn", dram_rasn, 1);
    check_value("DRAM_CASn", dram_casn, 1);
    check_value("DRAM_WEn", dram_wen, 4'hF);
    check_value("DRAM_A", dram_a, 0);
    check_value("DRAM_D", dram_d, 0);
  endtask

  // Called 1 ns after a rising edge, returns on the same grid
  task automatic run_request(input logic wr, input addr_t a, input word_t d, input strobe_t s,
                             output word_t rd, output logic e);
    int lat;
    int exp_lat;
    exp_lat = fixed_latency(wr, a);
    req = 1'b1;
    we = wr;
    addr = a;
    wdata = d;
    wstrb = s;
    lat = 0;
    do begin
      @(posedge clk);
      #1;
      req = 1'b0;
      lat++;
    end while (!done);
    rd = rdata;
    e = err;
    req_count++;
    if (exp_lat != 0) check_value("latency", lat, exp_lat);
    @(posedge clk);
    #1;
    check_value("done", done, 0); // Single cycle pulse
    check_value("done_count", done_count, req_count);
    if (in_dram(a)) check_dram_idle();
  endtask

  task automatic wait_interrupt();
    while (!sensor_interrupt) begin
      @(posedge clk);
      #1;
    end
    check_value("sensor_words", sensor_words, `SENSOR_DEPTH);
    check_value("sensor_en", sensor_en, 0);
  endtask

  task automatic read_sensor_buffer(input addr_t base);
    word_t expected;
    word_t rd;
    logic e;
    expected = 32'd73;
    for (int i = 0; i < `SENSOR_DEPTH; i++) begin
      expected = xorshift32(expected); // Same order as the sensor produced them
      run_request(1'b0, base + addr_t'(4 * i), '0, '0, rd, e);
      check_value($sformatf("sensor word %0d", i), rd, expected);
      check_value("err", e, 0);
      check_value("sensor_en", sensor_en, 0);
    end
  endtask

  task automatic load_patterns();
    int fd;
    int n;
    string line;
    string op;
    logic [31:0] fa, fw, fs, fr, fe;
    fd = $fopen("testbench/soc_patterns.txt", "r");
    if (fd == 0) fail_run("Could not open testbench/soc_patterns.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %h %h %h %h %h", op, fa, fw, fs, fr, fe);
        if (n == 6) begin
          pat_op.push_back(op);
          pat_addr.push_back(fa);
          pat_data.push_back(fw);
          pat_strb.push_back(fs[3:0]);
          pat_rdata.push_back(fr);
          pat_err.push_back(fe[0]);
        end
      end
    end
    $fclose(fd);
    if (pat_op.size() == 0) fail_run("The pattern file holds no requests");
  endtask

  // Synchronous ROM, output held between reads
  initial begin
    rom_out = '0;
    forever begin
      @(posedge clk);
      #1;
      if (rom_enable && rom_read) rom_out = word_t'(rom_address) * 32'h0101_0101;
    end
  end

  // DRAM with byte masks and a 3 cycle read delay
  initial begin
    int rd_wait;
    row_t act_row;
    logic [18:0] rd_key;
    logic [18:0] key;
    word_t w;
    dram_valid = 1'b0;
    dram_q = '0;
    rd_wait = 0;
    act_row = '0;
    rd_key = '0;
    forever begin
      @(posedge clk);
      #1;
      dram_valid = 1'b0;
      if (rd_wait > 0) begin
        rd_wait--;
        if (rd_wait == 0) begin
          dram_valid = 1'b1;
          dram_q = dram_mem.exists(rd_key) ? dram_mem[rd_key] : '0;
        end
      end
      if (!dram_csn && !dram_rasn && dram_casn && dram_wen == 4'hF) begin
        act_row = dram_a; // ACT
      end else if (!dram_csn && dram_rasn && !dram_casn) begin
        key = {act_row, dram_a[7:0]};
        if (dram_wen == 4'hF) begin
          rd_key = key;
          rd_wait = 3;
        end else begin
          w = dram_mem.exists(key) ? dram_mem[key] : '0;
          for (int b = 0; b < 4; b++) begin
            if (!dram_wen[b]) w[8*b +: 8] = dram_d[8*b +: 8];
          end
          dram_mem[key] = w;
        end
      end
    end
  end

  // Sensor offers a word every other cycle while enabled
  initial begin
    word_t state;
    state = 32'd73;
    sensor_ready = 1'b0;
    sensor_out = '0;
    forever begin
      @(posedge clk);
      #1;
      if (sensor_en && !sensor_ready) begin
        state = xorshift32(state);
        sensor_out = state;
        sensor_ready = 1'b1;
        sensor_words++;
      end else begin
        sensor_ready = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (done) done_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      fail_run($sformatf("Timeout after %0d cycles without finishing the patterns",
                         cycle_count));
    end
  end

  initial begin
    word_t rd;
    logic e;
    rst_sync = 1'b1;
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    wdata = '0;
    wstrb = '0;
    load_patterns();
    cycle_limit = pat_op.size() * 40 + 400;
    repeat (2) @(posedge clk);
    #1;
    rst_sync = 1'b0;
    check_value("done", done, 0);
    check_value("ROM_enable", rom_enable, 0);
    check_value("ROM_read", rom_read, 0);
    check_value("sensor_en", sensor_en, 0);
    check_value("sensor_interrupt", sensor_interrupt, 0);
    check_dram_idle();
    foreach (pat_op[i]) begin
      if (pat_op[i] == "R" || pat_op[i] == "W") begin
        run_request(pat_op[i] == "W", pat_addr[i], pat_data[i], pat_strb[i], rd, e);
        check_value("rdata", rd, pat_rdata[i]);
        check_value("err", e, pat_err[i]);
      end else if (pat_op[i] == "I") begin
        wait_interrupt();
      end else if (pat_op[i] == "B") begin
        read_sensor_buffer(pat_addr[i]);
      end else if (pat_op[i] == "Q") begin
        check_value("sensor_interrupt", sensor_interrupt, pat_rdata[i]);
      end else begin
        fail_run($sformatf("Unknown operation %s in pattern %0d", pat_op[i], i));
      end
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== testbench/soc_patterns.txt ====
# op addr wdata wstrb rdata err  (hex; R read, W write, I wait for interrupt,
# B read whole sensor buffer from addr, Q compare sensor_interrupt with rdata)
R 00000000 00000000 0 00000000 0
R 00000010 00000000 0 04040404 0
R 0000048C 00000000 0 24242423 0
R 00003FFC 00000000 0 0F0F0EFF 0
W 00000020 DEADBEEF F 00000000 1
W 20000400 11223344 F 00000000 0
R 20000400 00000000 0 11223344 0
W 20000400 AABBCCDD 5 00000000 0
R 20000400 00000000 0 11BB33DD 0
W 201FFFFC CAFEF00D F 00000000 0
R 201FFFFC 00000000 0 CAFEF00D 0
R 20000800 00000000 0 00000000 0
W 10000200 00000001 F 00000000 0
I 00000000 00000000 0 00000000 0
R 10000200 00000000 0 00000003 0
B 10000000 00000000 0 00000000 0
W 10000200 00000000 F 00000000 0
R 10000200 00000000 0 00000002 0
W 10000204 00000000 F 00000000 0
Q 00000000 00000000 0 00000000 0
R 10000200 00000000 0 00000000 0
R 30000000 00000000 0 00000000 1
W 00004000 12345678 F 00000000 1
R 10000400 00000000 0 00000000 1

// ==== flist.f ====
+incdir+design
design/soc_pkg.sv
design/req_decoder.sv
design/rom_port.sv
design/dram_ctrl.sv
design/sensor_buffer.sv
design/resp_mux.sv
design/soc_top.sv
testbench/tb_clock.sv
testbench/soc_tb.sv

// ==== Bender.yml ====
package:
  name: soc_periph

sources:
  - include_dirs:
      - design
    files:
      - design/soc_pkg.sv
      - design/req_decoder.sv
      - design/rom_port.sv
      - design/dram_ctrl.sv
      - design/sensor_buffer.sv
      - design/resp_mux.sv
      - design/soc_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_clock.sv
      - testbench/soc_tb.sv
